// ==== design/cpu_config.svh ====
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// datapath and memory sizing
`define WORD_W        32
`define MEM_AW        8
`define MEM_DEPTH     (1 << `MEM_AW)
`define NUM_REGS      8
`define REG_AW        3
`define ALU_CNTL_W    14
`define FLAGS_W       5

// alu control word, bits 0..6 pick exactly one operation
`define ALU_OP_ADD    0
`define ALU_OP_SUB    1
`define ALU_OP_AND    2
`define ALU_OP_OR     3
`define ALU_OP_XOR    4
`define ALU_OP_MUL    5
`define ALU_OP_DIV    6
`define ALU_SRC_INV   7
`define ALU_SRC_INC   8
`define ALU_USE_CARRY 9
`define ALU_NO_WR     10
`define ALU_CLEAR_CF  11
`define ALU_CLEAR_OF  12
`define ALU_PASS_B    13

// status flag positions, cf is the top bit
`define STAT_CF       4
`define STAT_PF       3
`define STAT_ZF       2
`define STAT_SF       1
`define STAT_OF       0

`endif

// ==== design/cpu_pkg.sv ====
`include "cpu_config.svh"

package cpu_pkg;

  typedef logic [`WORD_W-1:0]     word_t;
  typedef logic [`MEM_AW-1:0]     addr_t;
  typedef logic [`REG_AW-1:0]     reg_idx_t;
  typedef logic [`FLAGS_W-1:0]    flags_t;     // cf pf zf sf of, msb first
  typedef logic [`ALU_CNTL_W-1:0] alu_cntl_t;

  // instruction bits 31..26
  typedef enum logic [5:0] {
    OP_NOP  = 6'd0,
    OP_ADD  = 6'd1,
    OP_ADC  = 6'd2,
    OP_SUB  = 6'd3,
    OP_SBB  = 6'd4,
    OP_AND  = 6'd5,
    OP_OR   = 6'd6,
    OP_XOR  = 6'd7,
    OP_MUL  = 6'd8,
    OP_DIV  = 6'd9,
    OP_CMP  = 6'd10,
    OP_LDI  = 6'd11,
    OP_LD   = 6'd12,
    OP_ST   = 6'd13,
    OP_CLC  = 6'd14,
    OP_HALT = 6'd15
  } opcode_t;

  typedef enum logic [2:0] {
    S_FETCH,
    S_WAIT,
    S_DECODE,
    S_EXEC,
    S_MEM,
    S_HALT
  } seq_state_t;

endpackage

// ==== design/alu.sv ====
`timescale 1ns/1ps
`include "cpu_config.svh"

module alu (
  input  cpu_pkg::alu_cntl_t cntl,
  input  cpu_pkg::flags_t    status_in,
  input  cpu_pkg::word_t     opnd0_r,
  input  cpu_pkg::word_t     opnd1_r,
  output cpu_pkg::flags_t    status_out,
  output cpu_pkg::word_t     result
);
  import cpu_pkg::*;

  logic        carry;
  logic        cin;
  logic [32:0] a_ext;
  logic [32:0] b_ext;
  logic [32:0] sum;
  logic [63:0] product;
  word_t       quotient;
  logic        add_ovf;
  logic        mul_ovf;
  logic        div_zero;
  logic        cf_calc;
  logic        of_calc;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // shared adder for add/adc/sub/sbb/cmp
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign carry = cntl[`ALU_USE_CARRY] & status_in[`STAT_CF];
  assign cin   = cntl[`ALU_SRC_INC] ^ carry;     // sbb drops the +1 on borrow
  assign a_ext = {1'b0, opnd0_r};
  assign b_ext = cntl[`ALU_SRC_INV] ? ~{1'b0, opnd1_r} : {1'b0, opnd1_r};
  assign sum   = a_ext + b_ext + {32'b0, cin};  // bit 32 is carry, or borrow for sub

  // operands agree in sign, result does not
  assign add_ovf = (a_ext[31] == b_ext[31]) && (sum[31] != a_ext[31]);

  assign product  = {32'b0, opnd0_r} * {32'b0, opnd1_r};
  assign mul_ovf  = |product[63:32];
  assign div_zero = (opnd1_r == '0);
  assign quotient = div_zero ? '1 : opnd0_r / opnd1_r;

  always_comb begin
    case (1'b1)
      cntl[`ALU_OP_ADD],
      cntl[`ALU_OP_SUB]: result = sum[31:0];
      cntl[`ALU_OP_AND]: result = opnd0_r & opnd1_r;
      cntl[`ALU_OP_OR]:  result = opnd0_r | opnd1_r;
      cntl[`ALU_OP_XOR]: result = opnd0_r ^ opnd1_r;
      cntl[`ALU_OP_MUL]: result = product[31:0];
      cntl[`ALU_OP_DIV]: result = quotient;
      cntl[`ALU_PASS_B]: result = opnd1_r;     // ldi
      default:           result = '0;
    endcase
  end

  always_comb begin
    cf_calc = sum[32];
    of_calc = add_ovf;
    if (cntl[`ALU_OP_MUL]) begin
      cf_calc = mul_ovf;                       // product spilled into the upper word
      of_calc = mul_ovf;
    end else if (cntl[`ALU_OP_DIV]) begin
      cf_calc = div_zero;
      of_calc = 1'b0;
    end
  end

  // clear_cf wins over no_wr so clc keeps the other flags
  assign status_out[`STAT_CF] = cntl[`ALU_CLEAR_CF] ? 1'b0 :
                                cntl[`ALU_NO_WR]    ? status_in[`STAT_CF] : cf_calc;
  assign status_out[`STAT_PF] = cntl[`ALU_NO_WR] ? status_in[`STAT_PF] : ~^result[7:0];
  assign status_out[`STAT_ZF] = cntl[`ALU_NO_WR] ? status_in[`STAT_ZF] : (result == '0);
  assign status_out[`STAT_SF] = cntl[`ALU_NO_WR] ? status_in[`STAT_SF] : result[31];
  assign status_out[`STAT_OF] = cntl[`ALU_NO_WR]    ? status_in[`STAT_OF] :
                                cntl[`ALU_CLEAR_OF] ? 1'b0 : of_calc;

endmodule

// ==== design/op_decoder.sv ====
`timescale 1ns/1ps
`include "cpu_config.svh"

module op_decoder (
  input  cpu_pkg::opcode_t   opcode,
  output cpu_pkg::alu_cntl_t cntl,
  output logic               reg_we,
  output logic               flags_we,
  output logic               use_imm,
  output logic               is_load,
  output logic               is_store,
  output logic               is_halt
);
  import cpu_pkg::*;

  always_comb begin
    logic alu_op;                              // writes rd and flags

    alu_op   = 1'b0;
    cntl     = '0;
    reg_we   = 1'b0;
    flags_we = 1'b0;
    use_imm  = 1'b0;
    is_load  = 1'b0;
    is_store = 1'b0;
    is_halt  = 1'b0;

    case (opcode)
      OP_ADD, OP_ADC: begin
        alu_op                = 1'b1;
        cntl[`ALU_OP_ADD]     = 1'b1;
        cntl[`ALU_USE_CARRY]  = (opcode == OP_ADC);
      end
      OP_SUB, OP_SBB, OP_CMP: begin
        alu_op                = (opcode != OP_CMP);
        flags_we              = (opcode == OP_CMP);    // cmp keeps rd
        cntl[`ALU_OP_SUB]     = 1'b1;
        cntl[`ALU_SRC_INV]    = 1'b1;
        cntl[`ALU_SRC_INC]    = 1'b1;
        cntl[`ALU_USE_CARRY]  = (opcode == OP_SBB);
      end
      OP_AND, OP_OR, OP_XOR: begin
        alu_op                = 1'b1;
        cntl[`ALU_OP_AND]     = (opcode == OP_AND);
        cntl[`ALU_OP_OR]      = (opcode == OP_OR);
        cntl[`ALU_OP_XOR]     = (opcode == OP_XOR);
        cntl[`ALU_CLEAR_CF]   = 1'b1;
        cntl[`ALU_CLEAR_OF]   = 1'b1;
      end
      OP_MUL: begin
        alu_op                = 1'b1;
        cntl[`ALU_OP_MUL]     = 1'b1;
      end
      OP_DIV: begin
        alu_op                = 1'b1;
        cntl[`ALU_OP_DIV]     = 1'b1;
      end
      OP_LDI: begin
        reg_we                = 1'b1;
        use_imm               = 1'b1;
        cntl[`ALU_PASS_B]     = 1'b1;
        cntl[`ALU_NO_WR]      = 1'b1;
      end
      OP_CLC: begin
        flags_we              = 1'b1;
        cntl[`ALU_NO_WR]      = 1'b1;
        cntl[`ALU_CLEAR_CF]   = 1'b1;
      end
      OP_LD:   is_load  = 1'b1;
      OP_ST:   is_store = 1'b1;
      OP_HALT: is_halt  = 1'b1;
      default: cntl[`ALU_NO_WR] = 1'b1;        // nop and unused codes
    endcase

    if (alu_op) begin
      reg_we   = 1'b1;
      flags_we = 1'b1;
    end
  end

endmodule

// ==== design/reg_file.sv ====
`timescale 1ns/1ps
`include "cpu_config.svh"

module reg_file (
  input  logic              clk,
  input  logic              rst,
  input  cpu_pkg::reg_idx_t raddr_a,
  input  cpu_pkg::reg_idx_t raddr_b,
  input  logic              we,
  input  cpu_pkg::reg_idx_t waddr,
  input  cpu_pkg::word_t    wdata,
  input  logic              flags_we,
  input  cpu_pkg::flags_t   flags_in,
  output cpu_pkg::word_t    rdata_a,
  output cpu_pkg::word_t    rdata_b,
  output cpu_pkg::flags_t   flags
);
  import cpu_pkg::*;

  word_t regs [`NUM_REGS];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
      flags <= '0;
    end else begin
      if (we) begin
        regs[waddr] <= wdata;
      end
      if (flags_we) begin
        flags <= flags_in;
      end
    end
  end

  assign rdata_a = regs[raddr_a];  // rd, also the store data
  assign rdata_b = regs[raddr_b];

endmodule

// ==== design/core_seq.sv ====
`timescale 1ns/1ps

module core_seq (
  input  logic            clk,
  input  logic            rst,
  input  logic            fetch_gnt,
  input  logic            fetch_rvalid,
  input  cpu_pkg::word_t  rdata,
  input  logic            ls_done,
  input  cpu_pkg::word_t  ls_rdata,
  output logic            fetch_req,
  output cpu_pkg::addr_t  fetch_addr,
  output logic            ls_start,
  output logic            ls_we,
  output cpu_pkg::addr_t  ls_addr,
  output cpu_pkg::word_t  ls_wdata,
  output logic            halted,
  output cpu_pkg::flags_t flags
);
  import cpu_pkg::*;

  seq_state_t state;
  addr_t      pc;
  word_t      ir;
  opcode_t    opcode;
  word_t      imm;
  alu_cntl_t  cntl;
  logic       dec_reg_we;
  logic       dec_flags_we;
  logic       use_imm;
  logic       is_load;
  logic       is_store;
  logic       is_halt;
  word_t      rdata_a;
  word_t      rdata_b;
  word_t      opnd1;
  word_t      alu_result;
  flags_t     alu_flags;
  logic       rf_we;
  word_t      rf_wdata;
  logic       rf_flags_we;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // fetch / decode / execute
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= S_FETCH;
      pc        <= '0;
      fetch_req <= 1'b0;
    end else begin
      case (state)
        S_FETCH: begin
          fetch_req <= ~fetch_gnt;             // also raises it on the first cycle out of reset
          if (fetch_gnt) begin
            pc    <= pc + addr_t'(1);
            state <= S_WAIT;
          end
        end
        S_WAIT: begin
          if (fetch_rvalid) begin
            state <= S_DECODE;
          end
        end
        S_DECODE: begin
          if (is_halt) begin
            state <= S_HALT;
          end else if (is_load || is_store) begin
            state <= S_MEM;
          end else begin
            state <= S_EXEC;
          end
        end
        S_EXEC: begin
          fetch_req <= 1'b1;                   // next fetch with no idle cycle
          state     <= S_FETCH;
        end
        S_MEM: begin
          if (ls_done) begin
            fetch_req <= 1'b1;
            state     <= S_FETCH;
          end
        end
        S_HALT:  state <= S_HALT;              // until reset
        default: state <= S_FETCH;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == S_WAIT && fetch_rvalid) begin
      ir <= rdata;
    end
  end

  assign opcode = opcode_t'(ir[31:26]);
  assign imm    = {16'b0, ir[15:0]};

  op_decoder u_op_decoder (
    .opcode   (opcode),
    .cntl     (cntl),
    .reg_we   (dec_reg_we),
    .flags_we (dec_flags_we),
    .use_imm  (use_imm),
    .is_load  (is_load),
    .is_store (is_store),
    .is_halt  (is_halt)
  );

  reg_file u_reg_file (
    .clk      (clk),
    .rst      (rst),
    .raddr_a  (ir[25:23]),                     // rd
    .raddr_b  (ir[22:20]),                     // rs
    .we       (rf_we),
    .waddr    (ir[25:23]),
    .wdata    (rf_wdata),
    .flags_we (rf_flags_we),
    .flags_in (alu_flags),
    .rdata_a  (rdata_a),
    .rdata_b  (rdata_b),
    .flags    (flags)
  );

  alu u_alu (
    .cntl       (cntl),
    .status_in  (flags),
    .opnd0_r    (rdata_a),
    .opnd1_r    (opnd1),
    .status_out (alu_flags),
    .result     (alu_result)
  );

  assign opnd1       = use_imm ? imm : rdata_b;
  assign rf_we       = (state == S_EXEC && dec_reg_we) || (state == S_MEM && ls_done && is_load);
  assign rf_wdata    = (state == S_MEM) ? ls_rdata : alu_result;
  assign rf_flags_we = (state == S_EXEC) && dec_flags_we;

  assign fetch_addr = pc;
  assign ls_start   = (state == S_DECODE) && (is_load || is_store);
  assign ls_we      = is_store;
  assign ls_addr    = addr_t'(imm);            // word address from the low immediate bits
  assign ls_wdata   = rdata_a;
  assign halted     = (state == S_HALT);

endmodule

// ==== design/ld_st_unit.sv ====
`timescale 1ns/1ps

module ld_st_unit (
  input  logic           clk,
  input  logic           rst,
  input  logic           start,
  input  logic           we,
  input  cpu_pkg::addr_t addr,
  input  cpu_pkg::word_t wdata,
  input  logic           gnt,
  input  logic           rvalid,
  input  cpu_pkg::word_t rdata,
  output logic           req,
  output logic           req_we,
  output cpu_pkg::addr_t req_addr,
  output cpu_pkg::word_t req_wdata,
  output logic           done,
  output cpu_pkg::word_t load_data
);
  import cpu_pkg::*;

  logic  store_done;                           // write went out last cycle
  logic  load_wait;                            // read granted, data due
  word_t load_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      req        <= 1'b0;
      store_done <= 1'b0;
      load_wait  <= 1'b0;
    end else begin
      if (start) begin
        req <= 1'b1;
      end else if (gnt) begin
        req <= 1'b0;
      end
      store_done <= gnt & req_we;
      if (gnt && !req_we) begin
        load_wait <= 1'b1;
      end else if (rvalid) begin
        load_wait <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      req_we    <= we;
      req_addr  <= addr;
      req_wdata <= wdata;
    end
    if (rvalid) begin
      load_q <= rdata;
    end
  end

  assign done      = store_done | (rvalid & load_wait);
  assign load_data = rvalid ? rdata : load_q;  // valid in the done cycle and after

endmodule

// ==== design/mem_arbiter.sv ====
`timescale 1ns/1ps

module mem_arbiter (
  input  logic           clk,
  input  logic           rst,
  input  logic           ls_req,
  input  logic           ls_we,
  input  cpu_pkg::addr_t ls_addr,
  input  cpu_pkg::word_t ls_wdata,
  input  logic           fetch_req,
  input  logic           fetch_we,
  input  cpu_pkg::addr_t fetch_addr,
  input  cpu_pkg::word_t fetch_wdata,
  input  logic           host_req,
  input  logic           host_we,
  input  cpu_pkg::addr_t host_addr,
  input  cpu_pkg::word_t host_wdata,
  input  cpu_pkg::word_t mem_rdata,
  output logic           ls_gnt,
  output logic           ls_rvalid,
  output logic           fetch_gnt,
  output logic           fetch_rvalid,
  output logic           host_gnt,
  output logic           host_rvalid,
  output cpu_pkg::word_t rdata,
  output logic           mem_en,
  output logic           mem_we,
  output cpu_pkg::addr_t mem_addr,
  output cpu_pkg::word_t mem_wdata
);

  logic own_ls;                                // owner of last cycle's access
  logic own_fetch;
  logic own_host;
  logic rd_pend;                               // last access was a read
  logic busy;

  assign busy = own_ls | own_fetch | own_host;

  // fixed priority, one grant per two cycles
  assign ls_gnt    = ~busy & ls_req;
  assign fetch_gnt = ~busy & fetch_req & ~ls_req;
  assign host_gnt  = ~busy & host_req & ~ls_req & ~fetch_req;
  assign mem_en    = ls_gnt | fetch_gnt | host_gnt;

  always_comb begin
    if (ls_gnt) begin
      mem_we    = ls_we;
      mem_addr  = ls_addr;
      mem_wdata = ls_wdata;
    end else if (fetch_gnt) begin
      mem_we    = fetch_we;
      mem_addr  = fetch_addr;
      mem_wdata = fetch_wdata;
    end else begin
      mem_we    = host_gnt & host_we;
      mem_addr  = host_addr;
      mem_wdata = host_wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      own_ls    <= 1'b0;
      own_fetch <= 1'b0;
      own_host  <= 1'b0;
      rd_pend   <= 1'b0;
    end else begin
      own_ls    <= ls_gnt;
      own_fetch <= fetch_gnt;
      own_host  <= host_gnt;
      rd_pend   <= mem_en & ~mem_we;
    end
  end

  assign ls_rvalid    = rd_pend & own_ls;
  assign fetch_rvalid = rd_pend & own_fetch;
  assign host_rvalid  = rd_pend & own_host;
  assign rdata        = mem_rdata;             // shared, qualified by rvalid

endmodule

// ==== design/word_mem.sv ====
`timescale 1ns/1ps
`include "cpu_config.svh"

module word_mem (
  input  logic           clk,
  input  logic           en,
  input  logic           we,
  input  cpu_pkg::addr_t addr,
  input  cpu_pkg::word_t wdata,
  output cpu_pkg::word_t rdata
);
  import cpu_pkg::*;

  word_t mem [`MEM_DEPTH];

  always_ff @(posedge clk) begin
    if (en) begin
      if (we) begin
        mem[addr] <= wdata;
      end else begin
        rdata <= mem[addr];                    // one-cycle read
      end
    end
  end

endmodule

// ==== design/cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top (
  input  logic            clk,
  input  logic            rst,
  input  logic            host_req,
  input  logic            host_we,
  input  cpu_pkg::addr_t  host_addr,
  input  cpu_pkg::word_t  host_wdata,
  output logic            host_gnt,
  output logic            host_rvalid,
  output cpu_pkg::word_t  host_rdata,
  output logic            halted,
  output cpu_pkg::flags_t flags
);
  import cpu_pkg::*;

  // core fetch port
  logic  fetch_req;
  logic  fetch_gnt;
  logic  fetch_rvalid;
  addr_t fetch_addr;

  // core to load/store unit
  logic  ls_start;
  logic  ls_we;
  addr_t ls_addr;
  word_t ls_wdata;
  logic  ls_done;
  word_t ls_load_data;

  // load/store unit to arbiter
  logic  ls_req;
  logic  ls_req_we;
  addr_t ls_req_addr;
  word_t ls_req_wdata;
  logic  ls_gnt;
  logic  ls_rvalid;

  // arbiter to memory
  word_t arb_rdata;
  logic  mem_en;
  logic  mem_we;
  addr_t mem_addr;
  word_t mem_wdata;
  word_t mem_rdata;

  core_seq u_core_seq (
    .clk          (clk),
    .rst          (rst),
    .fetch_gnt    (fetch_gnt),
    .fetch_rvalid (fetch_rvalid),
    .rdata        (arb_rdata),
    .ls_done      (ls_done),
    .ls_rdata     (ls_load_data),
    .fetch_req    (fetch_req),
    .fetch_addr   (fetch_addr),
    .ls_start     (ls_start),
    .ls_we        (ls_we),
    .ls_addr      (ls_addr),
    .ls_wdata     (ls_wdata),
    .halted       (halted),
    .flags        (flags)
  );

  ld_st_unit u_ld_st_unit (
    .clk       (clk),
    .rst       (rst),
    .start     (ls_start),
    .we        (ls_we),
    .addr      (ls_addr),
    .wdata     (ls_wdata),
    .gnt       (ls_gnt),
    .rvalid    (ls_rvalid),
    .rdata     (arb_rdata),
    .req       (ls_req),
    .req_we    (ls_req_we),
    .req_addr  (ls_req_addr),
    .req_wdata (ls_req_wdata),
    .done      (ls_done),
    .load_data (ls_load_data)
  );

  mem_arbiter u_mem_arbiter (
    .clk          (clk),
    .rst          (rst),
    .ls_req       (ls_req),
    .ls_we        (ls_req_we),
    .ls_addr      (ls_req_addr),
    .ls_wdata     (ls_req_wdata),
    .fetch_req    (fetch_req),
    .fetch_we     (1'b0),                      // fetch only reads
    .fetch_addr   (fetch_addr),
    .fetch_wdata  ('0),
    .host_req     (host_req),
    .host_we      (host_we),
    .host_addr    (host_addr),
    .host_wdata   (host_wdata),
    .mem_rdata    (mem_rdata),
    .ls_gnt       (ls_gnt),
    .ls_rvalid    (ls_rvalid),
    .fetch_gnt    (fetch_gnt),
    .fetch_rvalid (fetch_rvalid),
    .host_gnt     (host_gnt),
    .host_rvalid  (host_rvalid),
    .rdata        (arb_rdata),
    .mem_en       (mem_en),
    .mem_we       (mem_we),
    .mem_addr     (mem_addr),
    .mem_wdata    (mem_wdata)
  );

  word_mem u_word_mem (
    .clk   (clk),
    .en    (mem_en),
    .we    (mem_we),
    .addr  (mem_addr),
    .wdata (mem_wdata),
    .rdata (mem_rdata)
  );

  assign host_rdata = arb_rdata;

endmodule

// ==== sim/tb_ref_model.svh ====
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// pf is set when the low byte holds an even number of ones
function automatic logic even_parity(input logic [7:0] b);
  int ones;
  ones = 0;
  for (int i = 0; i < 8; i++) begin
    ones += int'(b[i]);
  end
  return (ones % 2) == 0;
endfunction

// returns {flags, value written to rd}; flags are cf pf zf sf of
function automatic logic [36:0] model_alu(input opcode_t op, input word_t a, input word_t b,
                                          input flags_t fin);
  logic [32:0] wide;
  logic [63:0] prod;
  word_t       res;
  word_t       wr;
  logic        cf;
  logic        of;
  logic        bin;
  res = a;
  cf  = 1'b0;
  of  = 1'b0;
  case (op)
    OP_ADD, OP_ADC: begin
      bin  = (op == OP_ADC) ? fin[4] : 1'b0;
      wide = {1'b0, a} + {1'b0, b} + {32'b0, bin};
      res  = wide[31:0];
      cf   = wide[32];
      of   = (a[31] == b[31]) && (res[31] != a[31]);
    end
    OP_SUB, OP_SBB, OP_CMP: begin
      bin  = (op == OP_SBB) ? fin[4] : 1'b0;
      wide = {1'b0, a} - {1'b0, b} - {32'b0, bin};  // borrow wraps into bit 32
      res  = wide[31:0];
      cf   = wide[32];
      of   = (a[31] != b[31]) && (res[31] != a[31]);
    end
    OP_AND: res = a & b;
    OP_OR:  res = a | b;
    OP_XOR: res = a ^ b;
    OP_MUL: begin
      prod = {32'b0, a} * {32'b0, b};
      res  = prod[31:0];
      cf   = |prod[63:32];
      of   = cf;
    end
    OP_DIV: begin
      res = (b == 32'd0) ? 32'hffff_ffff : a / b;
      cf  = (b == 32'd0);
    end
    default: res = a;
  endcase
  wr = (op == OP_CMP) ? a : res;                   // cmp leaves rd alone
  return {cf, even_parity(res[7:0]), res == 32'd0, res[31], of, wr};
endfunction

`endif

// ==== sim/tb_cpu_top.sv ====
`timescale 1ns/1ps

module tb_cpu_top;
  import cpu_pkg::*;

  `include "tb_ref_model.svh"

  localparam logic [15:0] DATA_BASE  = 16'h0080;
  localparam logic [15:0] RES_BASE   = 16'h00a0;
  localparam logic [15:0] SPARE_ADDR = 16'h00f0;
  localparam word_t       SPARE_WORD = {4{8'hf0 ^ 8'h5c}};

  logic   clk;
  logic   rst;
  logic   host_req;
  logic   host_we;
  addr_t  host_addr;
  word_t  host_wdata;
  logic   host_gnt;
  logic   host_rvalid;
  word_t  host_rdata;
  logic   halted;
  flags_t flags;

  word_t  prog [$];
  word_t  data_words [$];
  integer seed;
  int     mismatch_count;
  int     fail_count;
  int     host_reads;
  logic   run_active;
  int     wd_count;
  int     wd_limit;

  cpu_top u_cpu_top (
    .clk         (clk),
    .rst         (rst),
    .host_req    (host_req),
    .host_we     (host_we),
    .host_addr   (host_addr),
    .host_wdata  (host_wdata),
    .host_gnt    (host_gnt),
    .host_rvalid (host_rvalid),
    .host_rdata  (host_rdata),
    .halted      (halted),
    .flags       (flags)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // watchdog
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin
    run_active = 1'b0;
    wd_count   = 0;
    wd_limit   = 2000;
    while (!(run_active && wd_count > wd_limit)) begin
      @(posedge clk);
      if (run_active) wd_count++;
    end
    $display("core never halted within %0d cycles", wd_limit);
    $display("%0d mismatches, %0d other failures", mismatch_count, fail_count + 1);
    $display("Test failed");
    $finish;
  end

  function automatic word_t enc(input opcode_t op, input reg_idx_t rd, input reg_idx_t rs,
                                input logic [15:0] imm);
    return {op, rd, rs, 4'b0, imm};
  endfunction

  task automatic check_word(input string name, input word_t exp, input word_t act);
    assert (act === exp) else begin
      $display("Mismatch %s: expected %h, actual %h", name, exp, act);
      mismatch_count++;
    end
  endtask

  task automatic host_access(input logic we, input addr_t addr, input word_t wdata,
                             output word_t rdata);
    int waited;
    waited = 0;
    rdata  = '0;
    @(posedge clk);
    host_req   <= 1'b1;
    host_we    <= we;
    host_addr  <= addr;
    host_wdata <= wdata;
    @(negedge clk);
    while (!host_gnt && waited < 200) begin
      @(negedge clk);
      waited++;
    end
    if (!host_gnt) begin
      $display("host access to address %h was never granted", addr);
      fail_count++;
    end
    @(posedge clk);                                // grant taken on this edge
    host_req <= 1'b0;
    host_we  <= 1'b0;
    if (!we) begin
      @(negedge clk);
      if (host_rvalid) begin
        rdata = host_rdata;
      end else begin
        $display("host read of address %h returned no data", addr);
        fail_count++;
      end
    end
  endtask

  task automatic host_write(input addr_t addr, input word_t data);
    word_t unused;
    host_access(1'b1, addr, data, unused);
  endtask

  task automatic check_mem(input string name, input logic [15:0] addr, input word_t exp);
    word_t got;
    host_access(1'b0, addr_t'(addr), '0, got);
    check_word(name, exp, got);
  endtask

  task automatic host_contention(input string name);
    word_t got;
    while (!halted) begin
      host_access(1'b0, addr_t'(SPARE_ADDR), '0, got);
      host_reads++;
      check_word({name, " host read"}, SPARE_WORD, got);
    end
  endtask

  // program and data are loaded with the core in reset
  task automatic run_program(input string name, input bit contend);
    int start_reads;
    start_reads = host_reads;
    @(posedge clk);
    rst <= 1'b1;
    repeat (3) @(posedge clk);
    for (int i = 0; i < prog.size(); i++) host_write(addr_t'(i), prog[i]);
    for (int i = 0; i < data_words.size(); i++) host_write(addr_t'(DATA_BASE + i), data_words[i]);
    if (contend) host_write(addr_t'(SPARE_ADDR), SPARE_WORD);
    @(posedge clk);
    rst        <= 1'b0;
    wd_count   = 0;
    wd_limit   = 40 * prog.size() + 2000;
    run_active = 1'b1;
    fork
      begin
        while (!halted) @(negedge clk);
      end
      begin
        if (contend) host_contention(name);
      end
    join
    run_active = 1'b0;
    if (contend && host_reads == start_reads) begin
      $display("%s: no host read completed while the program ran", name);
      fail_count++;
    end
  endtask

  task automatic binop_test(input string name, input opcode_t op, input word_t a,
                            input word_t b, input bit contend);
    logic [36:0] pre;
    logic [36:0] exp;
    pre        = model_alu(OP_ADD, 32'h8000_0000, 32'h8000_0000, 5'b0);
    exp        = model_alu(op, a, b, pre[36:32]);
    data_words = {a, b, 32'h8000_0000};
    prog       = {};
    prog.push_back(enc(OP_LD, 3'd1, 3'd0, DATA_BASE));
    prog.push_back(enc(OP_LD, 3'd2, 3'd0, DATA_BASE + 16'd1));
    prog.push_back(enc(OP_LD, 3'd3, 3'd0, DATA_BASE + 16'd2));
    prog.push_back(enc(OP_ADD, 3'd3, 3'd3, 16'd0));  // sets cf and of ahead of the op
    prog.push_back(enc(op, 3'd1, 3'd2, 16'd0));
    prog.push_back(enc(OP_ST, 3'd1, 3'd0, RES_BASE));
    prog.push_back(enc(OP_HALT, 3'd0, 3'd0, 16'd0));
    run_program(name, contend);
    check_mem(name, RES_BASE, exp[31:0]);
    check_word({name, " flags"}, {27'b0, exp[36:32]}, {27'b0, flags});
  endtask

  task automatic carry_chain_test(input string name, input bit contend);
    logic [63:0] a64;
    logic [63:0] b64;
    logic [63:0] sum64;
    logic [63:0] dif64;
    logic [36:0] add_r;
    logic [36:0] exp;
    a64        = {$random(seed), $random(seed)};
    b64        = {$random(seed), $random(seed)};
    a64[31:30] = 2'b10;                              // low words carry and borrow
    b64[31:30] = 2'b11;
    sum64 = a64 + b64;
    dif64 = a64 - b64;
    add_r = model_alu(OP_ADD, 32'hffff_ffff, 32'd1, 5'b0);
    exp   = model_alu(OP_ADC, 32'd5, 32'd1, {1'b0, add_r[35:32]});  // after clc
    data_words = {a64[31:0], a64[63:32], b64[31:0], b64[63:32], 32'hffff_ffff};
    prog = {};
    prog.push_back(enc(OP_LD, 3'd1, 3'd0, DATA_BASE));
    prog.push_back(enc(OP_LD, 3'd2, 3'd0, DATA_BASE + 16'd1));
    prog.push_back(enc(OP_LD, 3'd3, 3'd0, DATA_BASE + 16'd2));
    prog.push_back(enc(OP_LD, 3'd4, 3'd0, DATA_BASE + 16'd3));
    prog.push_back(enc(OP_ADD, 3'd1, 3'd3, 16'd0));
    prog.push_back(enc(OP_ADC, 3'd2, 3'd4, 16'd0));
    prog.push_back(enc(OP_ST, 3'd1, 3'd0, RES_BASE));
    prog.push_back(enc(OP_ST, 3'd2, 3'd0, RES_BASE + 16'd1));
    prog.push_back(enc(OP_LD, 3'd1, 3'd0, DATA_BASE));
    prog.push_back(enc(OP_LD, 3'd2, 3'd0, DATA_BASE + 16'd1));
    prog.push_back(enc(OP_SUB, 3'd1, 3'd3, 16'd0));
    prog.push_back(enc(OP_SBB, 3'd2, 3'd4, 16'd0));
    prog.push_back(enc(OP_ST, 3'd1, 3'd0, RES_BASE + 16'd2));
    prog.push_back(enc(OP_ST, 3'd2, 3'd0, RES_BASE + 16'd3));
    prog.push_back(enc(OP_LD, 3'd5, 3'd0, DATA_BASE + 16'd4));
    prog.push_back(enc(OP_LDI, 3'd6, 3'd0, 16'd1));
    prog.push_back(enc(OP_ADD, 3'd5, 3'd6, 16'd0));  // sets cf
    prog.push_back(enc(OP_CLC, 3'd0, 3'd0, 16'd0));
    prog.push_back(enc(OP_LDI, 3'd7, 3'd0, 16'd5));
    prog.push_back(enc(OP_ADC, 3'd7, 3'd6, 16'd0));
    prog.push_back(enc(OP_ST, 3'd7, 3'd0, RES_BASE + 16'd4));
    prog.push_back(enc(OP_HALT, 3'd0, 3'd0, 16'd0));
    run_program(name, contend);
    check_mem({name, " sum lo"}, RES_BASE, sum64[31:0]);
    check_mem({name, " sum hi"}, RES_BASE + 16'd1, sum64[63:32]);
    check_mem({name, " diff lo"}, RES_BASE + 16'd2, dif64[31:0]);
    check_mem({name, " diff hi"}, RES_BASE + 16'd3, dif64[63:32]);
    check_mem({name, " adc after clc"}, RES_BASE + 16'd4, 32'd6);
    check_word({name, " flags"}, {27'b0, exp[36:32]}, {27'b0, flags});
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // test sequence
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin
    word_t a;
    word_t b;
    seed           = 32'hcb73_3548;
    rst            = 1'b1;
    host_req       = 1'b0;
    host_we        = 1'b0;
    host_addr      = '0;
    host_wdata     = '0;
    mismatch_count = 0;
    fail_count     = 0;
    host_reads     = 0;
    repeat (3) @(posedge clk);

    for (int n = 0; n < 4; n++) begin
      a = $random(seed);
      b = $random(seed);
      binop_test("add random", OP_ADD, a, b, 1'b0);
      binop_test("sub random", OP_SUB, a, b, 1'b0);
    end
    binop_test("add overflow", OP_ADD, 32'h7fff_ffff, 32'd1, 1'b0);
    binop_test("sub overflow", OP_SUB, 32'h8000_0000, 32'd1, 1'b0);
    binop_test("sub zero", OP_SUB, 32'h1234_5678, 32'h1234_5678, 1'b0);
    carry_chain_test("carry chain", 1'b0);

    for (int n = 0; n < 2; n++) begin
      a = $random(seed);
      b = $random(seed);
      binop_test("and", OP_AND, a, b, 1'b0);
      binop_test("or", OP_OR, a, b, 1'b0);
      binop_test("xor", OP_XOR, a, b, 1'b0);
      binop_test("cmp", OP_CMP, a, b, 1'b0);
    end

    a = $random(seed);
    b = $random(seed);
    binop_test("mul large", OP_MUL, a, b, 1'b0);
    binop_test("mul small", OP_MUL, {16'b0, a[15:0]}, {16'b0, b[15:0]}, 1'b0);
    binop_test("div", OP_DIV, a, {24'b0, b[7:0]} | 32'd1, 1'b0);
    binop_test("div by zero", OP_DIV, a, 32'd0, 1'b0);

    carry_chain_test("carry chain contention", 1'b1);
    binop_test("add contention", OP_ADD, $random(seed), $random(seed), 1'b1);

    $display("%0d mismatches, %0d other failures, %0d host reads under contention",
             mismatch_count, fail_count, host_reads);
    if (mismatch_count == 0 && fail_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== src.f ====
+incdir+design
+incdir+sim
design/cpu_pkg.sv
design/alu.sv
design/op_decoder.sv
design/reg_file.sv
design/core_seq.sv
design/ld_st_unit.sv
design/mem_arbiter.sv
design/word_mem.sv
design/cpu_top.sv
sim/tb_cpu_top.sv

// ==== Makefile ====
TOP = tb_cpu_top

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): src.f design/*.sv design/*.svh sim/*.sv sim/*.svh
	verilator --binary --timing -Wno-fatal -f src.f --top-module $(TOP) -j 0

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@if grep -q "Test failed" sim.log; then exit 1; fi
	@grep -q "Test completed successfully" sim.log

lint:
	verilator --lint-only --timing -Wall -f src.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
